//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = fetch_tb
FILELIST = src.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- logic/branch_decode.sv
`timescale 1ns/1ps

module branch_decode (
	input cpu_pkg::instr_u instr,
	branch_intf.dec bus
);

	always_comb begin
		bus.opcode = instr.b_fmt.opcode;
		bus.sub_op_b = 1'b0;
		bus.sub_op_bz = 4'd0; // No BZ condition matches zero
		bus.sub_op_j = 1'b0;
		bus.imm14 = '0;
		bus.imm16 = '0;
		bus.imm24 = '0;
		bus.rt = '0;
		bus.ra = '0;
		bus.rb = '0;

		case (instr.b_fmt.opcode)
			cpu_pkg::op_ty_b: begin
				bus.rt = instr.b_fmt.rt;
				bus.ra = instr.b_fmt.ra;
				bus.sub_op_b = instr.b_fmt.sub_op_b;
				bus.imm14 = instr.b_fmt.imm14;
			end
			cpu_pkg::op_ty_bz: begin
				bus.rt = instr.bz_fmt.rt;
				bus.sub_op_bz = instr.bz_fmt.sub_op_bz;
				bus.imm16 = instr.bz_fmt.imm16;
			end
			cpu_pkg::op_ty_j: begin
				bus.sub_op_j = instr.j_fmt.sub_op_j;
				bus.imm24 = instr.j_fmt.imm24;
			end
			cpu_pkg::op_jr: begin
				bus.rb = instr.jr_fmt.rb;
			end
			default: ; // Falls through to PC+4
		endcase
	end

	// Reserved JR bits must be clear
	always_comb begin
		if (instr.jr_fmt.opcode == cpu_pkg::op_jr) begin
			jr_pad_zero: assert (instr.jr_fmt.pad_hi == '0 && instr.jr_fmt.pad_lo == '0)
				else $error("JR word has nonzero pad bits");
		end
	end

endmodule

//--- logic/branch_intf.sv
`timescale 1ns/1ps

interface branch_intf;
	// Decoded fields
	logic [cpu_pkg::opcode_w-1:0] opcode;
	logic sub_op_b;
	logic [3:0] sub_op_bz;
	logic sub_op_j;
	logic [13:0] imm14;
	logic [15:0] imm16;
	logic [23:0] imm24;
	logic [cpu_pkg::reg_addr_w-1:0] rt;
	logic [cpu_pkg::reg_addr_w-1:0] ra;
	logic [cpu_pkg::reg_addr_w-1:0] rb;

	// Operand flags from the register file
	logic rt_ra_equal;
	logic rt_zero;
	logic rt_negative;
	logic [31:0] rb_data;

	modport dec (output opcode, sub_op_b, sub_op_bz, sub_op_j, imm14, imm16, imm24,
		rt, ra, rb);
	modport opr (input rt, ra, rb, output rt_ra_equal, rt_zero, rt_negative, rb_data);
	modport pc (input opcode, sub_op_b, sub_op_bz, sub_op_j, imm14, imm16, imm24,
		rt, ra, rb, rt_ra_equal, rt_zero, rt_negative, rb_data);

endinterface

//--- logic/cpu_pkg.sv
package cpu_pkg;

	localparam int opcode_w = 6;
	localparam int reg_addr_w = 5;

	// Control-flow opcodes
	localparam logic [opcode_w-1:0] op_ty_b = 6'h26;
	localparam logic [opcode_w-1:0] op_ty_bz = 6'h27;
	localparam logic [opcode_w-1:0] op_ty_j = 6'h24;
	localparam logic [opcode_w-1:0] op_jr = 6'h25;

	localparam logic sub_beq = 1'b0;
	localparam logic sub_bne = 1'b1;

	localparam logic [3:0] sub_beqz = 4'd2;
	localparam logic [3:0] sub_bnez = 4'd3;
	localparam logic [3:0] sub_bgez = 4'd4;
	localparam logic [3:0] sub_bltz = 4'd5;
	localparam logic [3:0] sub_bgtz = 4'd6;
	localparam logic [3:0] sub_blez = 4'd7;

	localparam logic sub_jal = 1'b1; // 0 is a plain jump

	localparam logic [reg_addr_w-1:0] link_reg = 5'd30;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] ra;
		logic sub_op_b;
		logic pad;
		logic [13:0] imm14;
	} b_fmt_t;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic [reg_addr_w-1:0] rt;
		logic [3:0] sub_op_bz;
		logic pad;
		logic [15:0] imm16;
	} bz_fmt_t;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic sub_op_j;
		logic pad;
		logic [23:0] imm24;
	} j_fmt_t;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic [4:0] pad_hi;
		logic [reg_addr_w-1:0] rb;
		logic [15:0] pad_lo;
	} jr_fmt_t;

	// One instruction word, four views
	typedef union packed {
		b_fmt_t b_fmt;
		bz_fmt_t bz_fmt;
		j_fmt_t j_fmt;
		jr_fmt_t jr_fmt;
	} instr_u;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic link;
	} trace_t;

endpackage

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter int CREDITS = 4,
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input logic clock,
	input logic reset,
	output logic [31:0] fetch_pc,
	input logic [31:0] instr,
	input logic reg_wr_en,
	input logic [cpu_pkg::reg_addr_w-1:0] reg_wr_addr,
	input logic [31:0] reg_wr_data,
	output logic trace_valid,
	output cpu_pkg::trace_t trace_rec,
	input logic credit_return
);

	branch_intf bus ();

	logic [31:0] current_pc;
	logic [31:0] next_pc;
	logic do_jump_link;
	logic enable_pc;
	logic link_en;

	assign fetch_pc = current_pc;
	assign link_en = do_jump_link & enable_pc; // Only when the JAL executes

	branch_decode i_branch_decode (
		.instr(instr),
		.bus(bus.dec)
	);

	operand_read i_operand_read (
		.clock(clock),
		.reset(reset),
		.reg_wr_en(reg_wr_en),
		.reg_wr_addr(reg_wr_addr),
		.reg_wr_data(reg_wr_data),
		.link_en(link_en),
		.link_data(current_pc + 32'd4),
		.bus(bus.opr)
	);

	pc_unit #(.RESET_PC(RESET_PC)) i_pc_unit (
		.clock(clock),
		.reset(reset),
		.enable_pc(enable_pc),
		.bus(bus.pc),
		.current_pc(current_pc),
		.next_pc(next_pc),
		.do_jump_link(do_jump_link)
	);

	trace_out #(.CREDITS(CREDITS)) i_trace_out (
		.clock(clock),
		.reset(reset),
		.credit_return(credit_return),
		.cur_pc(current_pc),
		.nxt_pc(next_pc),
		.link(do_jump_link),
		.enable_pc(enable_pc),
		.trace_valid(trace_valid),
		.trace_rec(trace_rec)
	);

endmodule

//--- logic/operand_read.sv
`timescale 1ns/1ps

module operand_read (
	input logic clock,
	input logic reset,
	input logic reg_wr_en,
	input logic [cpu_pkg::reg_addr_w-1:0] reg_wr_addr,
	input logic [31:0] reg_wr_data,
	input logic link_en,
	input logic [31:0] link_data,
	branch_intf.opr bus
);

	logic [31:0] regs [32];
	logic [31:0] rt_data;
	logic [31:0] ra_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (link_en) begin
			regs[cpu_pkg::link_reg] <= link_data; // Link beats preload
		end else if (reg_wr_en && reg_wr_addr != '0) begin
			regs[reg_wr_addr] <= reg_wr_data;
		end
	end

	// r0 is never written
	assign rt_data = regs[bus.rt];
	assign ra_data = regs[bus.ra];
	assign bus.rb_data = regs[bus.rb];

	// Branch flags
	assign bus.rt_ra_equal = (rt_data == ra_data);
	assign bus.rt_zero = (rt_data == 32'd0);
	assign bus.rt_negative = rt_data[31]; // Sign bit

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input logic clock,
	input logic reset,
	input logic enable_pc,
	branch_intf.pc bus,
	output logic [31:0] current_pc,
	output logic [31:0] next_pc,
	output logic do_jump_link
);

	localparam logic [2:0] sel_pc4 = 3'd0;
	localparam logic [2:0] sel_imm14 = 3'd1;
	localparam logic [2:0] sel_imm16 = 3'd2;
	localparam logic [2:0] sel_imm24 = 3'd3;
	localparam logic [2:0] sel_reg = 3'd4;

	logic [2:0] select_pc;
	logic bz_taken;

	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= RESET_PC;
		end else if (enable_pc) begin
			current_pc <= next_pc;
		end
	end

	// Branch-on-zero conditions
	always_comb begin
		case (bus.sub_op_bz)
			cpu_pkg::sub_beqz: bz_taken = bus.rt_zero;
			cpu_pkg::sub_bnez: bz_taken = !bus.rt_zero;
			cpu_pkg::sub_bgez: bz_taken = !bus.rt_negative;
			cpu_pkg::sub_bltz: bz_taken = bus.rt_negative;
			cpu_pkg::sub_bgtz: bz_taken = !bus.rt_zero && !bus.rt_negative;
			cpu_pkg::sub_blez: bz_taken = bus.rt_zero || bus.rt_negative;
			default: bz_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (bus.opcode)
			cpu_pkg::op_ty_b: begin
				// BEQ wants equal, BNE wants unequal
				if (bus.rt_ra_equal == (bus.sub_op_b == cpu_pkg::sub_beq))
					select_pc = sel_imm14;
				else
					select_pc = sel_pc4;
			end
			cpu_pkg::op_ty_bz: select_pc = bz_taken ? sel_imm16 : sel_pc4;
			cpu_pkg::op_ty_j: select_pc = sel_imm24;
			cpu_pkg::op_jr: select_pc = sel_reg;
			default: select_pc = sel_pc4;
		endcase
	end

	// Targets relative to this instruction's PC
	always_comb begin
		case (select_pc)
			sel_imm14: next_pc = current_pc + {{17{bus.imm14[13]}}, bus.imm14, 1'b0};
			sel_imm16: next_pc = current_pc + {{15{bus.imm16[15]}}, bus.imm16, 1'b0};
			sel_imm24: next_pc = current_pc + {{7{bus.imm24[23]}}, bus.imm24, 1'b0};
			sel_reg: next_pc = bus.rb_data;
			default: next_pc = current_pc + 32'd4;
		endcase
	end

	assign do_jump_link = (bus.opcode == cpu_pkg::op_ty_j) && (bus.sub_op_j == cpu_pkg::sub_jal);

	pc_halfword: assert property (@(posedge clock) disable iff (reset) current_pc[0] == 1'b0)
		else $error("PC lost halfword alignment");

endmodule

//--- logic/trace_out.sv
`timescale 1ns/1ps

module trace_out #(
	parameter int CREDITS = 4
) (
	input logic clock,
	input logic reset,
	input logic credit_return,
	input logic [31:0] cur_pc,
	input logic [31:0] nxt_pc,
	input logic link,
	output logic enable_pc,
	output logic trace_valid,
	output cpu_pkg::trace_t trace_rec
);

	localparam int cnt_w = $clog2(CREDITS + 1);

	logic [cnt_w-1:0] credit_cnt;

	assign enable_pc = (credit_cnt != '0);

	// Credit leaves with the record it pays for
	always_ff @(posedge clock) begin
		if (reset) begin
			credit_cnt <= cnt_w'(CREDITS);
			trace_valid <= 1'b0;
		end else begin
			credit_cnt <= credit_cnt - cnt_w'(enable_pc) + cnt_w'(credit_return);
			trace_valid <= enable_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (enable_pc) begin
			trace_rec.pc <= cur_pc;
			trace_rec.next_pc <= nxt_pc;
			trace_rec.link <= link;
		end
	end

	// A return with every credit home would push the count past the limit
	credit_bound: assert property (@(posedge clock) disable iff (reset)
		credit_return |-> credit_cnt < cnt_w'(CREDITS))
		else $error("Credit returned with none outstanding");

endmodule

//--- src.f
logic/cpu_pkg.sv
logic/branch_intf.sv
logic/branch_decode.sv
logic/operand_read.sv
logic/pc_unit.sv
logic/trace_out.sv
logic/fetch_top.sv
verif/fetch_tb.sv

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	localparam int credits = 4;
	localparam logic [31:0] reset_pc = 32'h0;
	localparam int n_exec = 400; // Sled, directed block and over 300 random
	localparam int stim_cycles = 10 + 16 + 2 * n_exec + 2 * credits + 10;
	localparam int timeout_cycles = 4 * stim_cycles;

	// Operands: equal pair, unequal, zero, positive, negative, then JR targets
	localparam logic [4:0] preload_reg [12] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6,
		5'd7, 5'd8, 5'd10, 5'd11, 5'd12, 5'd13};
	localparam logic [31:0] preload_val [12] = '{32'd5, 32'd5, 32'd7, 32'd0, 32'd100,
		32'hffff_ff00, 32'd1, 32'h8000_0000, 32'h800, 32'h900, 32'ha00, 32'hb00};

	logic clock;
	logic reset;
	logic [31:0] fetch_pc;
	logic [31:0] instr;
	logic reg_wr_en;
	logic [4:0] reg_wr_addr;
	logic [31:0] reg_wr_data;
	logic trace_valid;
	cpu_pkg::trace_t trace_rec;
	logic credit_return;

	logic [31:0] imem [1024];
	logic [31:0] shadow [32];
	logic [31:0] exp_pc;
	cpu_pkg::trace_t exp_rec;
	logic [9:0] idx;
	int rec_count;
	int owed; // Records seen but not yet paid back
	int returned;
	int cycles;

	fetch_top #(.CREDITS(credits), .RESET_PC(reset_pc)) i_fetch_top (
		.clock(clock),
		.reset(reset),
		.fetch_pc(fetch_pc),
		.instr(instr),
		.reg_wr_en(reg_wr_en),
		.reg_wr_addr(reg_wr_addr),
		.reg_wr_data(reg_wr_data),
		.trace_valid(trace_valid),
		.trace_rec(trace_rec),
		.credit_return(credit_return)
	);

	assign instr = imem[fetch_pc[11:2]]; // Wraps every 4 KB

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] branch_word(input logic sub, input logic [4:0] rt,
		input logic [4:0] ra, input int imm);
		return {cpu_pkg::op_ty_b, rt, ra, sub, 1'b0, 14'(imm)};
	endfunction

	function automatic logic [31:0] zero_branch_word(input logic [3:0] sub,
		input logic [4:0] rt, input int imm);
		return {cpu_pkg::op_ty_bz, rt, sub, 1'b0, 16'(imm)};
	endfunction

	function automatic logic [31:0] jump_word(input logic sub, input int imm);
		return {cpu_pkg::op_ty_j, sub, 1'b0, 24'(imm)};
	endfunction

	function automatic logic [31:0] jr_word(input logic [4:0] rb);
		return {cpu_pkg::op_jr, 5'd0, rb, 16'd0};
	endfunction

	// Even halfword count keeps targets word-aligned
	function automatic int small_imm();
		int m;
		m = 2 * (1 + int'($urandom % 16));
		return ($urandom % 2 == 0) ? m : -m;
	endfunction

	function automatic logic [31:0] random_word();
		case ($urandom % 6)
			0: return branch_word(1'($urandom % 2), 5'($urandom % 9), 5'($urandom % 9),
				small_imm());
			1: return zero_branch_word(4'(2 + $urandom % 6), 5'($urandom % 9), small_imm());
			2: return jump_word(1'b0, small_imm());
			3: return jump_word(cpu_pkg::sub_jal, small_imm());
			4: return jr_word(($urandom % 5 == 0) ? cpu_pkg::link_reg : 5'(10 + $urandom % 4));
			default: return {6'($urandom % 32), 26'($urandom)}; // Opcode below 0x24
		endcase
	endfunction

	function automatic cpu_pkg::trace_t ref_step(input logic [31:0] pc,
		input cpu_pkg::instr_u w, input logic [31:0] regs [32]);
		cpu_pkg::trace_t t;
		logic [31:0] a;
		logic taken;
		t.pc = pc;
		t.next_pc = pc + 32'd4;
		t.link = 1'b0;
		case (w.b_fmt.opcode)
			cpu_pkg::op_ty_b: begin
				a = regs[w.b_fmt.rt];
				taken = (a == regs[w.b_fmt.ra]) ^ (w.b_fmt.sub_op_b == cpu_pkg::sub_bne);
				if (taken)
					t.next_pc = pc + (32'($signed(w.b_fmt.imm14)) << 1);
			end
			cpu_pkg::op_ty_bz: begin
				a = regs[w.bz_fmt.rt];
				case (w.bz_fmt.sub_op_bz)
					cpu_pkg::sub_beqz: taken = (a == 32'd0);
					cpu_pkg::sub_bnez: taken = (a != 32'd0);
					cpu_pkg::sub_bgez: taken = ($signed(a) >= 0);
					cpu_pkg::sub_bltz: taken = ($signed(a) < 0);
					cpu_pkg::sub_bgtz: taken = ($signed(a) > 0);
					cpu_pkg::sub_blez: taken = ($signed(a) <= 0);
					default: taken = 1'b0;
				endcase
				if (taken)
					t.next_pc = pc + (32'($signed(w.bz_fmt.imm16)) << 1);
			end
			cpu_pkg::op_ty_j: begin
				t.next_pc = pc + (32'($signed(w.j_fmt.imm24)) << 1);
				t.link = (w.j_fmt.sub_op_j == cpu_pkg::sub_jal);
			end
			cpu_pkg::op_jr: t.next_pc = regs[w.jr_fmt.rb];
			default: t.link = 1'b0;
		endcase
		return t;
	endfunction

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "Run stopped on error");
	endtask

	task automatic check_trace(input cpu_pkg::trace_t got, input cpu_pkg::trace_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL at %0t: trace %h/%h/%b, expected %h/%h/%b",
				$time, got.pc, got.next_pc, got.link, exp.pc, exp.next_pc, exp.link));
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_with_failure($sformatf("FAIL at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// One falling edge, counting arrivals and maybe paying one credit back
	task automatic step(input bit allow_return);
		@(negedge clock);
		if (trace_valid)
			owed++;
		if (allow_return && owed > 0 && $urandom % 4 != 0) begin
			credit_return = 1'b1;
			owed--;
			returned++;
		end else begin
			credit_return = 1'b0;
		end
	endtask

	task automatic place(input logic [31:0] w, input bit with_gap);
		imem[idx] = w;
		idx++;
		if (with_gap) begin
			imem[idx] = 32'h0; // Landing word when not taken
			idx++;
		end
	endtask

	initial begin
		cycles = 0;
		forever begin
			@(posedge clock);
			cycles++;
			if (cycles >= timeout_cycles)
				stop_with_failure("Timeout: the run did not finish in the expected cycles");
		end
	end

	// Monitor follows the program order and checks every record
	initial begin
		exp_pc = reset_pc;
		rec_count = 0;
		forever begin
			@(negedge clock);
			if (trace_valid) begin
				exp_rec = ref_step(exp_pc, imem[exp_pc[11:2]], shadow);
				check_trace(trace_rec, exp_rec);
				if (exp_rec.link)
					shadow[cpu_pkg::link_reg] = exp_rec.pc + 32'd4;
				exp_pc = exp_rec.next_pc;
				rec_count++;
			end
		end
	end

	initial begin
		void'($urandom(35));
		reset = 1'b1;
		credit_return = 1'b0;
		reg_wr_en = 1'b0;
		reg_wr_addr = '0;
		reg_wr_data = '0;
		owed = 0;
		returned = 0;
		for (int i = 0; i < 32; i++)
			shadow[5'(i)] = '0;
		for (int i = 0; i < 1024; i++)
			imem[10'(i)] = random_word();
		for (int i = 0; i < 8; i++)
			imem[10'(i)] = 32'h0; // Runs while registers load
		idx = 10'd8;
		place(branch_word(cpu_pkg::sub_beq, 5'd1, 5'd2, 4), 1'b1);
		place(branch_word(cpu_pkg::sub_beq, 5'd1, 5'd3, 4), 1'b1);
		place(branch_word(cpu_pkg::sub_bne, 5'd1, 5'd3, 4), 1'b1);
		place(branch_word(cpu_pkg::sub_bne, 5'd1, 5'd2, 4), 1'b1);
		for (int s = 2; s < 8; s++)
			for (int r = 4; r < 7; r++)
				place(zero_branch_word(4'(s), 5'(r), 4), 1'b1);
		place(jump_word(1'b0, 4), 1'b1);
		place(jump_word(cpu_pkg::sub_jal, 8), 1'b0); // To the JR r30 stub
		place(jump_word(1'b0, 8), 1'b0); // Return point, skips the stub
		place(32'h0, 1'b0);
		place(32'h0, 1'b0);
		place(jr_word(cpu_pkg::link_reg), 1'b0);
		place(jr_word(5'd10), 1'b0); // Into the random area

		repeat (10) @(negedge clock);
		reset = 1'b0;
		check_pc(fetch_pc, reset_pc, "fetch_pc after reset");
		check_count(rec_count, 0, "records before the first executed cycle");

		for (int i = 0; i < 12; i++) begin
			step(1'b0);
			reg_wr_en = 1'b1;
			reg_wr_addr = preload_reg[4'(i)];
			reg_wr_data = preload_val[4'(i)];
			shadow[preload_reg[4'(i)]] = preload_val[4'(i)];
		end
		step(1'b0);
		reg_wr_en = 1'b0;
		check_count(rec_count, credits, "records with no credit returned");
		check_pc(fetch_pc, reset_pc + 32'(4 * credits), "fetch_pc out of credits");
		step(1'b0);
		step(1'b0);
		check_pc(fetch_pc, reset_pc + 32'(4 * credits), "fetch_pc held in stall");

		while (rec_count < n_exec)
			step(1'b1);
		while (owed < credits)
			step(1'b0);
		step(1'b0);
		step(1'b0);
		check_pc(fetch_pc, exp_pc, "fetch_pc after drain");
		check_count(rec_count, returned + credits, "records against credits spent");
		$display("Simulation passed");
		$finish;
	end

endmodule
